/* flist.f */
+incdir+logic
logic/mastermind_pkg.sv
logic/game_control.sv
logic/peg_scorer.sv
logic/mastermind_top.sv
tests/score_monitor.sv
tests/mastermind_checker.sv
tests/mastermind_tb.sv

/* Bender.yml */
package:
  name: mastermind

sources:
  - include_dirs:
      - logic
    files:
      - logic/mastermind_pkg.sv
      - logic/game_control.sv
      - logic/peg_scorer.sv
      - logic/mastermind_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/score_monitor.sv
      - tests/mastermind_checker.sv
      - tests/mastermind_tb.sv

/* tests/mastermind_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_params.svh"

module mastermind_tb;

    localparam int MAX_GAP = 3;
    localparam int LATENCY = `MM_SCORE_CYCLES + 1;
    localparam int WAIT_LIMIT = 40;
    localparam int GUESSES = 250;
    localparam int PEGS = (GUESSES + 40) * `MM_PEGS;
    // each peg costs its gap plus two cycles, doubled for margin
    localparam int WATCHDOG_NS = 2 * 8 * (PEGS * (MAX_GAP + 2) + GUESSES * 20);

    logic                     clock = 1'b0;
    logic                     resetn;
    mastermind_pkg::peg_t     peg_i;
    logic                     peg_valid_i;
    mastermind_pkg::phase_e   phase_o;
    mastermind_pkg::score_t   score_o;
    logic                     score_valid_o;
    logic                     solved_o;
    logic                     round_over_o;

    logic [31:0]              rng;
    mastermind_pkg::peg_row_t cur_code;
    bit                       in_round = 1'b0;
    int                       guess_cnt = 0;
    int                       errors = 0;
    int                       err_base = 0;
    int                       tests = 0;

    always #4 clock = ~clock;

    mastermind_top mastermind_top_i (
        .clock         (clock),
        .resetn        (resetn),
        .peg_i         (peg_i),
        .peg_valid_i   (peg_valid_i),
        .phase_o       (phase_o),
        .score_o       (score_o),
        .score_valid_o (score_valid_o),
        .solved_o      (solved_o),
        .round_over_o  (round_over_o)
    );

    score_monitor score_monitor_i (
        .clock         (clock),
        .resetn        (resetn),
        .score_i       (score_o),
        .score_valid_i (score_valid_o),
        .solved_i      (solved_o),
        .round_over_i  (round_over_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic mastermind_pkg::peg_t peg_of(input mastermind_pkg::peg_row_t row,
                                                    input int idx);
        case (idx)
            0: return row.peg0;
            1: return row.peg1;
            2: return row.peg2;
            default: return row.peg3;
        endcase
    endfunction

    function automatic mastermind_pkg::peg_row_t make_row(input int a, input int b,
                                                          input int c, input int d);
        mastermind_pkg::peg_row_t row;
        row.peg0 = mastermind_pkg::peg_t'(a);
        row.peg1 = mastermind_pkg::peg_t'(b);
        row.peg2 = mastermind_pkg::peg_t'(c);
        row.peg3 = mastermind_pkg::peg_t'(d);
        return row;
    endfunction

    function automatic mastermind_pkg::peg_row_t rand_row();
        logic [31:0] r;
        r = next_rand();
        return mastermind_pkg::peg_row_t'(r[`MM_PEGS*`MM_COLOUR_W-1:0]);
    endfunction

    function automatic mastermind_pkg::peg_row_t unsolved_row();
        mastermind_pkg::peg_row_t r;
        r = rand_row();
        if (r == cur_code) begin
            r.peg0 = r.peg0 ^ 1'b1;
        end
        return r;
    endfunction

    // red counts exact places, white is colour overlap minus red
    function automatic mastermind_pkg::score_t score_ref(input mastermind_pkg::peg_row_t code,
                                                         input mastermind_pkg::peg_row_t guess);
        mastermind_pkg::score_t s;
        int red;
        int common;
        int nc;
        int ng;
        red = 0;
        common = 0;
        for (int i = 0; i < `MM_PEGS; i++) begin
            if (peg_of(code, i) == peg_of(guess, i)) begin
                red++;
            end
        end
        for (int col = 0; col < (1 << `MM_COLOUR_W); col++) begin
            nc = 0;
            ng = 0;
            for (int i = 0; i < `MM_PEGS; i++) begin
                nc += (peg_of(code, i) == mastermind_pkg::peg_t'(col));
                ng += (peg_of(guess, i) == mastermind_pkg::peg_t'(col));
            end
            common += (nc < ng) ? nc : ng;
        end
        s = '0;
        s.red = 3'(red);
        s.white = 3'(common - red);
        return s;
    endfunction

    function automatic int total_errors();
        return errors + score_monitor_i.errors
               + mastermind_top_i.mastermind_checker_i.failures;
    endfunction

    task automatic expect_phase(input mastermind_pkg::phase_e want);
        if (phase_o != want) begin
            $display("mismatch at %0d ns: phase_o expected %0d got %0d", $time, want, phase_o);
            errors++;
        end
    endtask

    // waits out scoring before each strobe so no peg is dropped
    task automatic enter_row(input mastermind_pkg::peg_row_t row, input int max_gap);
        int gap;
        for (int i = 0; i < `MM_PEGS; i++) begin
            gap = next_rand() % (max_gap + 1);
            repeat (gap) @(posedge clock);
            @(negedge clock);
            while (phase_o == mastermind_pkg::PHASE_SCORE) @(negedge clock);
            @(posedge clock);
            peg_i <= peg_of(row, i);
            peg_valid_i <= 1'b1;
            @(posedge clock);
            peg_valid_i <= 1'b0;
        end
    endtask

    task automatic enter_code(input mastermind_pkg::peg_row_t row, input int max_gap);
        cur_code = row;
        enter_row(row, max_gap);
        @(negedge clock);
        expect_phase(mastermind_pkg::PHASE_GUESS);
        in_round = 1'b1;
        guess_cnt = 0;
    endtask

    // counts edges from the fourth guess peg, optionally strobing while scoring
    task automatic wait_score(input bit inject, input bit over);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
            if (inject && n <= `MM_SCORE_CYCLES) begin
                peg_i <= mastermind_pkg::peg_t'(next_rand());
                peg_valid_i <= 1'b1;
            end else begin
                peg_valid_i <= 1'b0;
            end
            @(negedge clock);
            seen = score_valid_o;
        end
        if (!seen) begin
            $display("error at %0d ns: no score arrived within %0d cycles of the guess",
                     $time, WAIT_LIMIT);
            errors++;
        end else begin
            if (n != LATENCY) begin
                $display("mismatch at %0d ns: score_valid_o latency expected %0d got %0d",
                         $time, LATENCY, n);
                errors++;
            end
            expect_phase(over ? mastermind_pkg::PHASE_CODE : mastermind_pkg::PHASE_GUESS);
        end
    endtask

    task automatic play_guess(input mastermind_pkg::peg_row_t guess, input int max_gap,
                              input bit inject);
        mastermind_pkg::score_t exp;
        bit win;
        bit over;
        guess_cnt++;
        exp = score_ref(cur_code, guess);
        exp.guess_num = 4'(guess_cnt);
        win = (exp.red == 3'(`MM_PEGS));
        over = win || (guess_cnt == `MM_MAX_GUESSES);
        score_monitor_i.push_expected(exp, win, over);
        enter_row(guess, max_gap);
        wait_score(inject, over);
        if (over) begin
            in_round = 1'b0;
            guess_cnt = 0;
        end
    endtask

    task automatic finish_round();
        while (in_round) begin
            play_guess(unsolved_row(), MAX_GAP, 1'b0);
        end
    endtask

    task automatic report_test(input string name);
        int now_err;
        @(posedge clock);
        @(negedge clock);
        now_err = total_errors();
        $display("test %s: %s, %0d errors", name, (now_err == err_base) ? "ok" : "failed",
                 now_err - err_base);
        err_base = now_err;
        tests++;
    endtask

    initial begin
        rng = 32'h2ef7d8af;
        resetn = 1'b0;
        peg_i = '0;
        peg_valid_i = 1'b0;
        repeat (3) @(posedge clock);
        resetn <= 1'b1;

        repeat (4) begin
            @(negedge clock);
            expect_phase(mastermind_pkg::PHASE_CODE);
            if (score_valid_o) begin
                $display("error at %0d ns: score_valid_o pulsed right after reset", $time);
                errors++;
            end
        end
        enter_code(make_row(1, 2, 3, 4), MAX_GAP);
        report_test("reset_and_code");

        // all wrong, permutation, repeats, then solved
        play_guess(make_row(5, 6, 7, 0), MAX_GAP, 1'b0);
        play_guess(make_row(2, 3, 4, 1), MAX_GAP, 1'b0);
        play_guess(make_row(1, 1, 1, 2), MAX_GAP, 1'b0);
        play_guess(make_row(1, 2, 3, 4), MAX_GAP, 1'b0);
        enter_code(make_row(3, 3, 5, 6), MAX_GAP);
        play_guess(make_row(5, 3, 3, 3), MAX_GAP, 1'b0);
        play_guess(make_row(6, 6, 3, 3), MAX_GAP, 1'b0);
        play_guess(make_row(3, 3, 5, 6), MAX_GAP, 1'b0);
        report_test("fixed_scores");

        repeat (200) begin
            if (!in_round) begin
                enter_code(rand_row(), MAX_GAP);
            end
            play_guess(rand_row(), MAX_GAP, 1'b0);
        end
        finish_round();
        report_test("random_scores");

        enter_code(rand_row(), MAX_GAP);
        play_guess(unsolved_row(), MAX_GAP, 1'b0);
        play_guess(cur_code, MAX_GAP, 1'b0);
        enter_code(rand_row(), MAX_GAP);
        repeat (`MM_MAX_GUESSES) play_guess(unsolved_row(), MAX_GAP, 1'b0);
        report_test("round_end");

        enter_code(rand_row(), MAX_GAP);
        repeat (`MM_MAX_GUESSES) play_guess(unsolved_row(), MAX_GAP, 1'b1);
        report_test("strobes_while_scoring");

        enter_code(rand_row(), 0);
        repeat (`MM_MAX_GUESSES) play_guess(unsolved_row(), 0, 1'b0);
        report_test("score_latency");

        if (score_monitor_i.pending() != 0) begin
            $display("error: %0d expected scores never appeared", score_monitor_i.pending());
            errors++;
        end
        $display("%0d tests, %0d scores checked, %0d errors", tests, score_monitor_i.checked,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/mastermind_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mastermind_checker (
    input wire                         clock,
    input wire                         resetn,
    input wire mastermind_pkg::phase_e phase_i,
    input wire                         score_valid_i,
    input wire                         solved_i,
    input wire                         round_over_i
);

    int failures = 0;

    valid_pulse: assert property (@(posedge clock) disable iff (!resetn)
        score_valid_i |=> !score_valid_i)
        else begin
            failures++;
            $error("score_valid_o stayed high for more than one cycle");
        end

    // win and round end only ride on a score
    flags_with_valid: assert property (@(posedge clock) disable iff (!resetn)
        (solved_i || round_over_i) |-> score_valid_i)
        else begin
            failures++;
            $error("solved_o or round_over_o raised without score_valid_o");
        end

    phase_after_score: assert property (@(posedge clock) disable iff (!resetn)
        score_valid_i |=> (phase_i != mastermind_pkg::PHASE_SCORE))
        else begin
            failures++;
            $error("phase_o still in scoring the cycle after a score");
        end

endmodule

bind mastermind_top mastermind_checker mastermind_checker_i (
    .clock         (clock),
    .resetn        (resetn),
    .phase_i       (phase_o),
    .score_valid_i (score_valid_o),
    .solved_i      (solved_o),
    .round_over_i  (round_over_o)
);

`default_nettype wire

/* tests/score_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module score_monitor (
    input wire                         clock,
    input wire                         resetn,
    input wire mastermind_pkg::score_t score_i,
    input wire                         score_valid_i,
    input wire                         solved_i,
    input wire                         round_over_i
);

    typedef struct packed {
        mastermind_pkg::score_t score;
        logic                   solved;
        logic                   round_over;
    } expect_t;

    expect_t exp_q [$];
    expect_t exp;
    int      checked = 0;
    int      errors = 0;

    task automatic push_expected(input mastermind_pkg::score_t score, input logic solved,
                                 input logic round_over);
        expect_t e;
        e.score = score;
        e.solved = solved;
        e.round_over = round_over;
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch at %0d ns: %s expected %0d got %0d", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    // outputs are registered, so the edge sees last cycle's values
    always @(posedge clock) begin
        if (resetn && score_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("error at %0d ns: a score arrived with no guess outstanding", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                checked++;
                compare("score_o.red", exp.score.red, score_i.red);
                compare("score_o.white", exp.score.white, score_i.white);
                compare("score_o.guess_num", exp.score.guess_num, score_i.guess_num);
                compare("solved_o", exp.solved, solved_i);
                compare("round_over_o", exp.round_over, round_over_i);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mastermind_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mastermind_top (
    input  wire                         clock,
    input  wire                         resetn,
    input  wire mastermind_pkg::peg_t   peg_i,
    input  wire                         peg_valid_i,
    output mastermind_pkg::phase_e      phase_o,
    output mastermind_pkg::score_t      score_o,
    output logic                        score_valid_o,
    output logic                        solved_o,
    output logic                        round_over_o
);

    mastermind_pkg::peg_row_t code_row;
    mastermind_pkg::peg_row_t guess_row;
    mastermind_pkg::score_t   result;
    logic                     score_start;
    logic                     result_valid;

    game_control game_control_i (
        .clock          (clock),
        .resetn         (resetn),
        .peg_i          (peg_i),
        .peg_valid_i    (peg_valid_i),
        .result_i       (result),
        .result_valid_i (result_valid),
        .phase_o        (phase_o),
        .code_row_o     (code_row),
        .guess_row_o    (guess_row),
        .score_start_o  (score_start),
        .score_o        (score_o),
        .score_valid_o  (score_valid_o),
        .solved_o       (solved_o),
        .round_over_o   (round_over_o)
    );

    // rows stay stable while the scorer walks them
    peg_scorer peg_scorer_i (
        .clock          (clock),
        .resetn         (resetn),
        .code_row_i     (code_row),
        .guess_row_i    (guess_row),
        .start_i        (score_start),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

endmodule

`default_nettype wire

/* logic/peg_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_params.svh"

module peg_scorer (
    input  wire                           clock,
    input  wire                           resetn,
    input  wire mastermind_pkg::peg_row_t code_row_i,
    input  wire mastermind_pkg::peg_row_t guess_row_i,
    input  wire                           start_i,
    output mastermind_pkg::score_t        result_o,
    output logic                          result_valid_o
);

    // step 0 is idle, steps 1..4 walk the code positions
    localparam int unsigned LAST_STEP = `MM_SCORE_CYCLES - 1;

    mastermind_pkg::peg_t code_pegs  [`MM_PEGS];
    mastermind_pkg::peg_t guess_pegs [`MM_PEGS];
    logic [`MM_PEGS-1:0]  exact;
    logic [`MM_PEGS-1:0]  code_used;
    logic [`MM_PEGS-1:0]  guess_used;
    logic [2:0]           red_sum;
    logic [2:0]           red_q;
    logic [2:0]           white_q;
    logic [2:0]           step_q;
    logic [1:0]           pos;
    logic                 hit;
    logic [1:0]           hit_idx;

    always_comb begin
        code_pegs[0]  = code_row_i.peg0;
        code_pegs[1]  = code_row_i.peg1;
        code_pegs[2]  = code_row_i.peg2;
        code_pegs[3]  = code_row_i.peg3;
        guess_pegs[0] = guess_row_i.peg0;
        guess_pegs[1] = guess_row_i.peg1;
        guess_pegs[2] = guess_row_i.peg2;
        guess_pegs[3] = guess_row_i.peg3;
    end

    // exact matches, all positions at once
    always_comb begin
        red_sum = 3'd0;
        for (int i = 0; i < `MM_PEGS; i++) begin
            exact[i] = (code_pegs[i] == guess_pegs[i]);
            red_sum  = red_sum + 3'(exact[i]);
        end
    end

    assign pos = 2'(step_q - 3'd1);

    // lowest free guess position with the same colour
    always_comb begin
        hit     = 1'b0;
        hit_idx = 2'd0;
        for (int j = `MM_PEGS - 1; j >= 0; j--) begin
            if (!code_used[pos] && !guess_used[j]
                && (guess_pegs[j] == code_pegs[pos])) begin
                hit     = 1'b1;
                hit_idx = 2'(j);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            step_q         <= 3'd0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= 1'b0;
            if (start_i) begin
                step_q <= 3'd1;
            end else if (step_q != 3'd0) begin
                if (step_q == 3'(LAST_STEP)) begin
                    step_q         <= 3'd0;
                    result_valid_o <= 1'b1;
                end else begin
                    step_q <= step_q + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_i) begin
            red_q      <= red_sum;
            white_q    <= 3'd0;
            code_used  <= exact;
            guess_used <= exact;
        end else if ((step_q != 3'd0) && hit) begin
            white_q             <= white_q + 3'd1;
            code_used[pos]      <= 1'b1;
            guess_used[hit_idx] <= 1'b1;
        end
    end

    // guess number is filled in by the control
    always_comb begin
        result_o           = '0;
        result_o.red       = red_q;
        result_o.white     = white_q;
    end

endmodule

`default_nettype wire

/* logic/game_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_params.svh"

module game_control (
    input  wire                           clock,
    input  wire                           resetn,
    input  wire mastermind_pkg::peg_t     peg_i,
    input  wire                           peg_valid_i,
    input  wire mastermind_pkg::score_t   result_i,
    input  wire                           result_valid_i,
    output mastermind_pkg::phase_e        phase_o,
    output mastermind_pkg::peg_row_t      code_row_o,
    output mastermind_pkg::peg_row_t      guess_row_o,
    output logic                          score_start_o,
    output mastermind_pkg::score_t        score_o,
    output logic                          score_valid_o,
    output logic                          solved_o,
    output logic                          round_over_o
);

    localparam int unsigned LAST_PEG = `MM_PEGS - 1;

    mastermind_pkg::phase_e   phase_q;
    mastermind_pkg::peg_row_t code_row_q;
    mastermind_pkg::peg_row_t guess_row_q;
    mastermind_pkg::score_t   stamped;
    logic [1:0]               peg_idx;
    logic [3:0]               guess_cnt;
    logic                     take_peg;
    logic                     row_done;
    logic                     solved;
    logic                     round_end;

    // replace one position of a row
    function automatic mastermind_pkg::peg_row_t put_peg(
        input mastermind_pkg::peg_row_t row,
        input logic [1:0]               idx,
        input mastermind_pkg::peg_t     peg
    );
        mastermind_pkg::peg_row_t next_row;
        next_row = row;
        case (idx)
            2'd0: next_row.peg0 = peg;
            2'd1: next_row.peg1 = peg;
            2'd2: next_row.peg2 = peg;
            default: next_row.peg3 = peg;
        endcase
        return next_row;
    endfunction

    // strobes during scoring are simply dropped
    assign take_peg = peg_valid_i && (phase_q != mastermind_pkg::PHASE_SCORE);
    assign row_done = (peg_idx == 2'(LAST_PEG));

    assign solved    = (result_i.red == 3'(`MM_PEGS));
    assign round_end = solved || (guess_cnt == 4'(`MM_MAX_GUESSES));

    always_comb begin
        stamped           = result_i;
        stamped.guess_num = guess_cnt;
    end

    always_ff @(posedge clock) begin
        if (take_peg) begin
            if (phase_q == mastermind_pkg::PHASE_CODE) begin
                code_row_q <= put_peg(code_row_q, peg_idx, peg_i);
            end else begin
                guess_row_q <= put_peg(guess_row_q, peg_idx, peg_i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase_q       <= mastermind_pkg::PHASE_CODE;
            peg_idx       <= 2'd0;
            guess_cnt     <= 4'd0;
            score_start_o <= 1'b0;
            score_o       <= '0;
            score_valid_o <= 1'b0;
            solved_o      <= 1'b0;
            round_over_o  <= 1'b0;
        end else begin
            score_start_o <= 1'b0;
            score_valid_o <= 1'b0;
            solved_o      <= 1'b0;
            round_over_o  <= 1'b0;

            if (take_peg) begin
                // index wraps back to 0 after the last peg
                peg_idx <= peg_idx + 2'd1;
                if (row_done) begin
                    if (phase_q == mastermind_pkg::PHASE_CODE) begin
                        phase_q <= mastermind_pkg::PHASE_GUESS;
                    end else begin
                        phase_q       <= mastermind_pkg::PHASE_SCORE;
                        score_start_o <= 1'b1;
                        guess_cnt     <= guess_cnt + 4'd1;
                    end
                end
            end

            if (result_valid_i) begin
                score_o       <= stamped;
                score_valid_o <= 1'b1;
                solved_o      <= solved;
                round_over_o  <= round_end;
                if (round_end) begin
                    // back to waiting for a fresh code
                    phase_q   <= mastermind_pkg::PHASE_CODE;
                    guess_cnt <= 4'd0;
                end else begin
                    phase_q <= mastermind_pkg::PHASE_GUESS;
                end
            end
        end
    end

    assign phase_o     = phase_q;
    assign code_row_o  = code_row_q;
    assign guess_row_o = guess_row_q;

endmodule

`default_nettype wire

/* logic/mastermind_pkg.sv */
`default_nettype none

`include "mastermind_params.svh"

package mastermind_pkg;

    typedef logic [`MM_COLOUR_W-1:0] peg_t;

    // peg0 sits in the low bits
    typedef struct packed {
        peg_t peg3;
        peg_t peg2;
        peg_t peg1;
        peg_t peg0;
    } peg_row_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] white;
        logic [3:0] guess_num;
    } score_t;

    typedef enum logic [1:0] {
        PHASE_CODE  = 2'd0,
        PHASE_GUESS = 2'd1,
        PHASE_SCORE = 2'd2
    } phase_e;

endpackage

`default_nettype wire

/* logic/mastermind_params.svh */
`ifndef MASTERMIND_PARAMS_SVH
`define MASTERMIND_PARAMS_SVH

// pegs in one code or guess row
`define MM_PEGS 4

// three bits gives eight colours
`define MM_COLOUR_W 3

// guesses allowed before the round is lost
`define MM_MAX_GUESSES 8

// scorer latency, start to result
`define MM_SCORE_CYCLES 5

`endif
